/* verilog.f */
+incdir+src
src/cart_loader_pkg.sv
src/download_receiver.sv
src/ines_header_parser.sv
src/rom_image_sequencer.sv
src/mem_write_port.sv
src/joypad_serializer.sv
src/cart_loader_top.sv
bench/tb_clock_gen.sv
bench/cart_loader_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = cart_loader_tb
FILELIST  = verilog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "All checks passed" > /dev/null

clean:
	rm -rf obj_dir

/* bench/cart_loader_tb.sv */
// Testbench for the cartridge loader top level.
// Runs a table of cartridge headers with random payloads through the download
// handshake, answers memory writes with random delays and checks the joypad port.

`timescale 1ns/1ps
`include "cart_loader_defines.svh"

module cart_loader_tb;

	localparam int NUM_ROWS    = 4;
	localparam int TRAIL_BYTES = 4;   // Bytes sent past the end of each image

	typedef struct packed {
		logic [95:0]                    hdr_tail;   // Header bytes 4 to 15 with byte 4 leftmost
		logic                           magic_good;
		logic                           invert;
		cart_loader_pkg::mapper_flags_t flags;
		logic                           error;
	} test_row_t;

	typedef enum {MEM_IDLE, MEM_WAIT, MEM_ACKED, MEM_CLOSING} mem_phase_t;

	logic clk;
	logic reset;
	logic dl_active;
	logic dl_req;
	logic [7:0] dl_data;
	logic dl_ack;
	logic invert_mirroring;
	logic mem_req;
	cart_loader_pkg::mem_write_t mem_wr;
	logic mem_ack;
	cart_loader_pkg::mapper_flags_t mapper_flags;
	logic busy;
	logic loaded;
	logic loader_error;
	logic machine_reset;
	logic pad_strobe;
	logic [1:0] pad_clock;
	logic [7:0] buttons_a;
	logic [7:0] buttons_b;
	logic swap;
	logic [1:0] pad_data;

	test_row_t rows [NUM_ROWS];
	cart_loader_pkg::mem_write_t exp_q [$];   // Writes the memory should see in order
	logic [15:0] data_lfsr = 16'd77;
	logic [15:0] delay_lfsr = 16'd77;
	logic table_ready = 1'b0;

	tb_clock_gen clock_gen_inst (.clk(clk), .reset(reset));

	cart_loader_top cart_loader_top_inst (.*);

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	task automatic draw_bits(inout logic [15:0] state, input int nbits, output logic [7:0] value);
		value = '0;
		for (int b = 0; b < nbits; b++) begin
			state = lfsr_step(state);
			value = {value[6:0], state[0]};
		end
	endtask

	function automatic logic [7:0] header_byte(input test_row_t row, input int idx);
		logic [31:0] magic;
		magic = row.magic_good ? 32'h4E45531A : 32'h4E45531B;
		if (idx < 4)
			return magic[8 * (3 - idx) +: 8];
		return row.hdr_tail[8 * (15 - idx) +: 8];
	endfunction

	function automatic int prg_length(input test_row_t row);
		return row.error ? 0 : int'(header_byte(row, 4)) << `CL_PRG_PAGE_SHIFT;
	endfunction

	function automatic int chr_length(input test_row_t row);
		return row.error ? 0 : int'(header_byte(row, 5)) << `CL_CHR_PAGE_SHIFT;
	endfunction

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_write(input cart_loader_pkg::mem_write_t got,
		input cart_loader_pkg::mem_write_t expected);
		if (got !== expected) begin
			$display("[ERROR] at %0t mem_wr: expected addr %h data %h, got addr %h data %h",
				$time, expected.addr, expected.data, got.addr, got.data);
			abort_run();
		end
	endtask

	task automatic check_flags(input cart_loader_pkg::mapper_flags_t got,
		input cart_loader_pkg::mapper_flags_t expected);
		if (got !== expected) begin
			$display("[ERROR] at %0t mapper_flags: expected %h, got %h", $time, expected, got);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("[ERROR] at %0t %s: expected %b, got %b", $time, name, expected, got);
			abort_run();
		end
	endtask

	// One four-phase transfer from the download side
	task automatic send_byte(input logic [7:0] value);
		dl_req  = 1'b1;
		dl_data = value;
		do begin
			@(negedge clk);
			check_bit("machine_reset", machine_reset, 1'b1);
		end while (!dl_ack);
		dl_req = 1'b0;
		do @(negedge clk); while (dl_ack);
	endtask

	task automatic run_row(input int r);
		test_row_t row;
		cart_loader_pkg::mem_write_t expected;
		logic [7:0] data;
		int prg_bytes;
		int chr_bytes;
		row = rows[r];
		prg_bytes = prg_length(row);
		chr_bytes = chr_length(row);
		invert_mirroring = row.invert;
		dl_active = 1'b1;
		@(negedge clk);
		for (int i = 0; i < `CL_HEADER_BYTES; i++)
			send_byte(header_byte(row, i));
		for (int i = 0; i < prg_bytes + chr_bytes; i++) begin
			draw_bits(data_lfsr, 8, data);
			expected.data = data;
			if (i < prg_bytes)
				expected.addr = `CL_ADDR_W'(i);
			else
				expected.addr = `CL_CHR_BASE + `CL_ADDR_W'(i - prg_bytes);
			exp_q.push_back(expected);
			send_byte(data);
			if (i == 0)
				check_bit("busy", busy, 1'b1);
		end
		for (int i = 0; i < TRAIL_BYTES; i++) begin
			draw_bits(data_lfsr, 8, data);
			send_byte(data);
		end
		while (exp_q.size() != 0 || mem_req)
			@(negedge clk);
		check_flags(mapper_flags, row.flags);
		check_bit("loaded", loaded, !row.error);
		check_bit("loader_error", loader_error, row.error);
		check_bit("busy", busy, 1'b0);
		dl_active = 1'b0;
		repeat (`CL_RESET_HOLD - 1) @(negedge clk);
		check_bit("machine_reset", machine_reset, 1'b1);
		@(negedge clk);
		check_bit("machine_reset", machine_reset, row.error);   // A failed load keeps it held
	endtask

	task automatic run_joypad(input logic swap_ports);
		logic [7:0] a_bits;
		logic [7:0] b_bits;
		logic [7:0] port0;
		logic [7:0] port1;
		draw_bits(data_lfsr, 8, a_bits);
		draw_bits(data_lfsr, 8, b_bits);
		port0 = swap_ports ? b_bits : a_bits;
		port1 = swap_ports ? a_bits : b_bits;
		buttons_a  = a_bits;
		buttons_b  = b_bits;
		swap       = swap_ports;
		pad_strobe = 1'b1;
		@(negedge clk);
		pad_strobe = 1'b0;
		@(negedge clk);
		for (int k = 0; k < 10; k++) begin   // Eight buttons and then zeros
			check_bit("pad_data[0]", pad_data[0], port0[0]);
			check_bit("pad_data[1]", pad_data[1], port1[0]);
			port0 = port0 >> 1;
			pad_clock = 2'b10;   // Port 0 only
			@(negedge clk);
			pad_clock = 2'b11;
			@(negedge clk);
			check_bit("pad_data[0]", pad_data[0], port0[0]);
			check_bit("pad_data[1]", pad_data[1], port1[0]);
			port1 = port1 >> 1;
			pad_clock = 2'b01;   // Port 1 only
			@(negedge clk);
			pad_clock = 2'b11;
			@(negedge clk);
		end
	endtask

	// Memory model that acknowledges each write after 0 to 3 cycles
	initial begin : mem_responder
		mem_phase_t phase;
		logic [7:0] delay;
		logic       dl_ack_seen;
		mem_ack     = 1'b0;
		phase       = MEM_IDLE;
		dl_ack_seen = 1'b0;
		forever begin
			@(negedge clk);
			if (dl_ack && !dl_ack_seen && phase != MEM_IDLE) begin
				$display("dl_ack rose at %0t while a memory write was still pending", $time);
				abort_run();
			end
			dl_ack_seen = dl_ack;
			if (phase == MEM_CLOSING) begin
				phase = MEM_IDLE;
			end else if (phase == MEM_ACKED && !mem_req) begin
				mem_ack = 1'b0;
				phase   = MEM_CLOSING;
			end
			if (phase == MEM_IDLE && mem_req) begin
				if (exp_q.size() == 0) begin
					$display("Unexpected memory write to %h at %0t", mem_wr.addr, $time);
					abort_run();
				end
				check_write(mem_wr, exp_q.pop_front());
				draw_bits(delay_lfsr, 2, delay);
				phase = MEM_WAIT;
			end
			if (phase == MEM_WAIT) begin
				if (delay == 8'd0) begin
					mem_ack = 1'b1;
					phase   = MEM_ACKED;
				end else
					delay = delay - 8'd1;
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (table_ready);
		limit = 2000;
		for (int r = 0; r < NUM_ROWS; r++)
			limit += 40 * (`CL_HEADER_BYTES + prg_length(rows[r]) + chr_length(rows[r])
				+ TRAIL_BYTES) + 2 * `CL_RESET_HOLD;
		repeat (limit) @(posedge clk);
		$display("Timeout after %0d cycles, the loader stopped answering", limit);
		abort_run();
	end

	initial begin
		dl_active        = 1'b0;
		dl_req           = 1'b0;
		dl_data          = 8'h00;
		invert_mirroring = 1'b0;
		pad_strobe       = 1'b0;
		pad_clock        = 2'b11;   // Idle high so the shifters move on the falling edge
		buttons_a        = 8'h00;
		buttons_b        = 8'h00;
		swap             = 1'b0;

		// Plain iNES with 1 PRG and 1 CHR page and mapper 4
		rows[0] = '{hdr_tail: 96'h01_01_41_00_00_00_00_00_00_00_00_00, magic_good: 1'b1,
			invert: 1'b0, flags: '{submapper: 8'h00, four_screen: 1'b0, chr_ram: 1'b0,
			mirroring: 1'b1, chr_size: 3'd0, prg_size: 3'd0, mapper: 8'h04}, error: 1'b0};
		// Bad magic and a dirty tail that masks the upper mapper nibble
		rows[1] = '{hdr_tail: 96'h05_03_10_70_22_00_00_00_55_00_00_00, magic_good: 1'b0,
			invert: 1'b0, flags: '{submapper: 8'h00, four_screen: 1'b0, chr_ram: 1'b0,
			mirroring: 1'b0, chr_size: 3'd2, prg_size: 3'd3, mapper: 8'h01}, error: 1'b1};
		// Trainer present and a saturated PRG size code
		rows[2] = '{hdr_tail: 96'hC8_40_05_00_00_01_00_00_00_00_00_00, magic_good: 1'b1,
			invert: 1'b1, flags: '{submapper: 8'h00, four_screen: 1'b0, chr_ram: 1'b0,
			mirroring: 1'b0, chr_size: 3'd6, prg_size: 3'd7, mapper: 8'h00}, error: 1'b1};
		// NES 2.0 with submapper, four-screen and CHR RAM
		rows[3] = '{hdr_tail: 96'h01_00_28_18_35_00_07_00_00_00_00_00, magic_good: 1'b1,
			invert: 1'b1, flags: '{submapper: 8'h35, four_screen: 1'b1, chr_ram: 1'b1,
			mirroring: 1'b1, chr_size: 3'd0, prg_size: 3'd0, mapper: 8'h12}, error: 1'b0};
		table_ready = 1'b1;

		wait (reset == 1'b0);
		@(negedge clk);
		repeat (3) begin
			check_bit("machine_reset", machine_reset, 1'b1);   // No download seen yet
			@(negedge clk);
		end
		run_joypad(1'b0);
		run_joypad(1'b1);
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("All checks passed");
		$finish;
	end

endmodule

/* bench/tb_clock_gen.sv */
// Clock and reset source for the loader testbench.
// Free-running 100 ns clock, reset held high for the first three cycles.

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;   // Released on a falling edge like every other input
	end

endmodule

/* src/cart_loader_top.sv */
// Cartridge loading front end with the controller port.
// Downloads are parsed and written to ROM memory, and the machine is
// kept in reset until a good image has settled.

`timescale 1ns/1ps
`include "cart_loader_defines.svh"

module cart_loader_top (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           dl_active,
	input  logic                           dl_req,
	input  logic [7:0]                     dl_data,
	output logic                           dl_ack,
	input  logic                           invert_mirroring,
	output logic                           mem_req,
	output cart_loader_pkg::mem_write_t    mem_wr,
	input  logic                           mem_ack,
	output cart_loader_pkg::mapper_flags_t mapper_flags,
	output logic                           busy,
	output logic                           loaded,
	output logic                           loader_error,
	output logic                           machine_reset,
	input  logic                           pad_strobe,
	input  logic [1:0]                     pad_clock,
	input  logic [7:0]                     buttons_a,
	input  logic [7:0]                     buttons_b,
	input  logic                           swap,
	output logic [1:0]                     pad_data
);

	cart_loader_pkg::mem_write_t wr;

	logic       byte_valid;
	logic [7:0] byte_data;
	logic       port_idle;
	logic       header_done;
	logic       header_ok;
	logic [7:0] prg_pages;
	logic [7:0] chr_pages;
	logic       wr_valid;
	logic       dl_active_q;
	logic       restart;
	logic       started;     // A download has been seen since reset
	logic [7:0] hold_cnt;

	assign restart = dl_active && !dl_active_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			started     <= 1'b0;
			hold_cnt    <= '0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active)
				started <= 1'b1;
			if (dl_active || busy)
				hold_cnt <= 8'(`CL_RESET_HOLD);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 8'd1;
		end
	end

	assign machine_reset = !started || dl_active || busy || (hold_cnt != '0) || loader_error;

	download_receiver download_receiver_inst (
		.clk        (clk),
		.reset      (reset),
		.dl_req     (dl_req),
		.dl_data    (dl_data),
		.port_idle  (port_idle),
		.dl_ack     (dl_ack),
		.byte_valid (byte_valid),
		.byte_data  (byte_data)
	);

	ines_header_parser ines_header_parser_inst (
		.clk              (clk),
		.reset            (reset),
		.restart          (restart),
		.byte_valid       (byte_valid),
		.byte_data        (byte_data),
		.invert_mirroring (invert_mirroring),
		.header_done      (header_done),
		.header_ok        (header_ok),
		.flags            (mapper_flags),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages)
	);

	rom_image_sequencer rom_image_sequencer_inst (
		.clk         (clk),
		.reset       (reset),
		.restart     (restart),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.header_done (header_done),
		.header_ok   (header_ok),
		.prg_pages   (prg_pages),
		.chr_pages   (chr_pages),
		.wr_valid    (wr_valid),
		.wr          (wr),
		.busy        (busy),
		.loaded      (loaded),
		.load_error  (loader_error)
	);

	mem_write_port mem_write_port_inst (
		.clk       (clk),
		.reset     (reset),
		.wr_valid  (wr_valid),
		.wr        (wr),
		.port_idle (port_idle),
		.mem_req   (mem_req),
		.mem_wr    (mem_wr),
		.mem_ack   (mem_ack)
	);

	joypad_serializer joypad_serializer_inst (
		.clk        (clk),
		.reset      (reset),
		.pad_strobe (pad_strobe),
		.pad_clock  (pad_clock),
		.buttons_a  (buttons_a),
		.buttons_b  (buttons_b),
		.swap       (swap),
		.pad_data   (pad_data)
	);

endmodule

/* src/joypad_serializer.sv */
// Serial shift registers of the two controller ports.
// A strobe loads both button sets, and a falling edge on a port's clock
// moves the next button to its data line. swap exchanges the ports.

`timescale 1ns/1ps

module joypad_serializer (
	input  logic       clk,
	input  logic       reset,
	input  logic       pad_strobe,
	input  logic [1:0] pad_clock,
	input  logic [7:0] buttons_a,
	input  logic [7:0] buttons_b,
	input  logic       swap,
	output logic [1:0] pad_data
);

	logic [1:0][7:0] shifter;
	logic [1:0]      pad_clock_q;
	logic [1:0]      clock_fall;

	assign clock_fall = pad_clock_q & ~pad_clock;

	always_ff @(posedge clk) begin
		if (reset) begin
			shifter     <= '0;
			pad_clock_q <= '0;
		end else begin
			pad_clock_q <= pad_clock;
			if (pad_strobe) begin
				shifter[0] <= swap ? buttons_b : buttons_a;
				shifter[1] <= swap ? buttons_a : buttons_b;
			end else begin
				for (int i = 0; i < 2; i++) begin
					if (clock_fall[i])
						shifter[i] <= {1'b0, shifter[i][7:1]};   // Zeros once empty
				end
			end
		end
	end

	assign pad_data = {shifter[1][0], shifter[0][0]};

endmodule

/* src/mem_write_port.sv */
// One-deep write buffer towards ROM memory.
// Holds a single write and offers it with a four-phase req/ack handshake;
// port_idle returns only once the memory has dropped its acknowledge.

`timescale 1ns/1ps

module mem_write_port (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        wr_valid,
	input  cart_loader_pkg::mem_write_t wr,
	output logic                        port_idle,
	output logic                        mem_req,
	output cart_loader_pkg::mem_write_t mem_wr,
	input  logic                        mem_ack
);

	logic pending;   // Write held until the handshake is fully closed

	assign port_idle = !pending;

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
			mem_req <= 1'b0;
		end else begin
			if (!pending && wr_valid) begin
				pending <= 1'b1;
				mem_req <= 1'b1;
			end else if (mem_req && mem_ack) begin
				mem_req <= 1'b0;   // Memory took it
			end else if (pending && !mem_req && !mem_ack) begin
				pending <= 1'b0;
			end
		end
	end

	// Stays stable while mem_req is up
	always_ff @(posedge clk) begin
		if (!pending && wr_valid)
			mem_wr <= wr;
	end

endmodule

/* src/rom_image_sequencer.sv */
// Places the PRG and CHR sections of the image into ROM memory.
// Each payload byte becomes one write request; PRG starts at address 0 and
// CHR at the CHR base. Bytes after the image are accepted and dropped.

`timescale 1ns/1ps
`include "cart_loader_defines.svh"

module rom_image_sequencer (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        restart,
	input  logic                        byte_valid,
	input  logic [7:0]                  byte_data,
	input  logic                        header_done,
	input  logic                        header_ok,
	input  logic [7:0]                  prg_pages,
	input  logic [7:0]                  chr_pages,
	output logic                        wr_valid,
	output cart_loader_pkg::mem_write_t wr,
	output logic                        busy,
	output logic                        loaded,
	output logic                        load_error
);

	cart_loader_pkg::loader_state_t state;

	logic [`CL_ADDR_W-1:0] addr;
	logic [`CL_ADDR_W-1:0] remaining;   // Bytes left in the current section
	logic [`CL_ADDR_W-1:0] prg_bytes;
	logic [`CL_ADDR_W-1:0] chr_bytes;
	logic                  in_payload;
	logic                  section_end;

	assign prg_bytes = {{(`CL_ADDR_W - 8){1'b0}}, prg_pages} << `CL_PRG_PAGE_SHIFT;
	assign chr_bytes = {{(`CL_ADDR_W - 8){1'b0}}, chr_pages} << `CL_CHR_PAGE_SHIFT;

	assign in_payload = (state == cart_loader_pkg::LOAD_PRG)
		|| (state == cart_loader_pkg::LOAD_CHR);

	assign wr_valid = byte_valid && in_payload && (remaining != '0);

	always_comb begin
		wr.addr = addr;
		wr.data = byte_data;
	end

	// Last byte going out now, or an empty section
	assign section_end = (remaining == '0)
		|| (wr_valid && (remaining == `CL_ADDR_W'(1)));

	always_ff @(posedge clk) begin
		if (reset || restart) begin
			state      <= cart_loader_pkg::LOAD_HEADER;
			busy       <= 1'b0;
			loaded     <= 1'b0;
			load_error <= 1'b0;
			addr       <= '0;
			remaining  <= '0;
		end else begin
			case (state)
				cart_loader_pkg::LOAD_HEADER: begin
					if (header_done) begin
						if (header_ok) begin
							state     <= cart_loader_pkg::LOAD_PRG;
							busy      <= 1'b1;
							addr      <= '0;
							remaining <= prg_bytes;
						end else begin
							state      <= cart_loader_pkg::LOAD_ERROR;
							load_error <= 1'b1;
						end
					end
				end
				cart_loader_pkg::LOAD_PRG: begin
					if (section_end) begin
						if (chr_pages == 8'd0) begin   // CHR RAM, nothing more to place
							state  <= cart_loader_pkg::LOAD_DONE;
							busy   <= 1'b0;
							loaded <= 1'b1;
						end else begin
							state     <= cart_loader_pkg::LOAD_CHR;
							addr      <= `CL_CHR_BASE;
							remaining <= chr_bytes;
						end
					end else if (wr_valid) begin
						addr      <= addr + 1'b1;
						remaining <= remaining - 1'b1;
					end
				end
				cart_loader_pkg::LOAD_CHR: begin
					if (section_end) begin
						state  <= cart_loader_pkg::LOAD_DONE;
						busy   <= 1'b0;
						loaded <= 1'b1;
					end else if (wr_valid) begin
						addr      <= addr + 1'b1;
						remaining <= remaining - 1'b1;
					end
				end
				default: ;   // Done or error, wait for the next download
			endcase
		end
	end

endmodule

/* src/ines_header_parser.sv */
// Collects the 16-byte iNES header from the download stream and decodes it.
// header_done pulses once after the last header byte; the decoded fields
// stay valid until the next restart.

`timescale 1ns/1ps
`include "cart_loader_defines.svh"

module ines_header_parser (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          restart,
	input  logic                          byte_valid,
	input  logic [7:0]                    byte_data,
	input  logic                          invert_mirroring,
	output logic                          header_done,
	output logic                          header_ok,
	output cart_loader_pkg::mapper_flags_t flags,
	output logic [7:0]                    prg_pages,
	output logic [7:0]                    chr_pages
);

	logic [7:0] hdr [`CL_HEADER_BYTES];
	logic [4:0] count;
	logic       capturing;
	logic       is_nes20;
	logic       is_dirty;

	// Smallest n with pages <= 2^n, saturating at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int n = 6; n >= 0; n--) begin
			if (pages <= (9'd1 << n))
				code = 3'(n);
		end
		return code;
	endfunction

	assign capturing = byte_valid && (count < 5'(`CL_HEADER_BYTES));

	always_ff @(posedge clk) begin
		if (reset || restart) begin
			count       <= '0;
			header_done <= 1'b0;
		end else begin
			header_done <= 1'b0;
			if (capturing) begin
				count <= count + 5'd1;
				if (count == 5'(`CL_HEADER_BYTES - 1))
					header_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capturing)
			hdr[count[3:0]] <= byte_data;
	end

	assign prg_pages = hdr[4];
	assign chr_pages = hdr[5];

	// "NES" followed by EOF, and no trainer block
	assign header_ok = (hdr[0] == 8'h4E) && (hdr[1] == 8'h45) && (hdr[2] == 8'h53)
		&& (hdr[3] == 8'h1A) && !hdr[6][2];

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Old dumps often carry junk in the tail of an iNES 1.0 header
	assign is_dirty = !is_nes20 && (|{hdr[9][7:1], hdr[10], hdr[11], hdr[12],
		hdr[13], hdr[14], hdr[15]});

	always_comb begin
		flags.submapper   = is_nes20 ? hdr[8] : 8'h00;
		flags.four_screen = hdr[6][3];
		flags.chr_ram     = (chr_pages == 8'd0);
		flags.mirroring   = hdr[6][0] ^ invert_mirroring;
		flags.chr_size    = size_code(chr_pages);
		flags.prg_size    = size_code(prg_pages);
		flags.mapper      = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	end

endmodule

/* src/download_receiver.sv */
// Receive side of the four-phase download handshake.
// Each accepted byte gives a one-cycle byte_valid strobe with the data held
// on byte_data. A byte is only accepted while the write port is empty.

`timescale 1ns/1ps

module download_receiver (
	input  logic       clk,
	input  logic       reset,
	input  logic       dl_req,
	input  logic [7:0] dl_data,
	input  logic       port_idle,
	output logic       dl_ack,
	output logic       byte_valid,
	output logic [7:0] byte_data
);

	logic accept;

	// New request, previous one fully closed, and room downstream
	assign accept = dl_req && !dl_ack && port_idle;

	always_ff @(posedge clk) begin
		if (reset) begin
			dl_ack     <= 1'b0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= accept;
			if (accept)
				dl_ack <= 1'b1;
			else if (dl_ack && !dl_req)
				dl_ack <= 1'b0;   // Source released, close the handshake
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			byte_data <= dl_data;
	end

endmodule

/* src/cart_loader_pkg.sv */
// Shared types of the cartridge loader.
// Modules refer to them with the cart_loader_pkg:: prefix.

`include "cart_loader_defines.svh"

package cart_loader_pkg;

	// One byte on its way to ROM memory
	typedef struct packed {
		logic [`CL_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} mem_write_t;

	// Mapper configuration handed to the emulated machine
	typedef struct packed {
		logic [7:0] submapper;   // NES 2.0 only
		logic       four_screen;
		logic       chr_ram;     // No CHR ROM in the image
		logic       mirroring;
		logic [2:0] chr_size;    // log2 of 8 KiB pages, rounded up
		logic [2:0] prg_size;    // log2 of 16 KiB pages, rounded up
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_DONE,
		LOAD_ERROR
	} loader_state_t;

endpackage

/* src/cart_loader_defines.svh */
// Fixed sizes of the iNES cartridge format and the loader memory map.
// Included by the loader package and by the modules that size counters
// or addresses from these values.

`ifndef CART_LOADER_DEFINES_SVH
`define CART_LOADER_DEFINES_SVH

// Cartridge header length in bytes
`define CL_HEADER_BYTES 16

// Byte address into the ROM memory
`define CL_ADDR_W 22

// 16 KiB PRG pages
`define CL_PRG_PAGE_SHIFT 14

// 8 KiB CHR pages
`define CL_CHR_PAGE_SHIFT 13

// CHR data sits in the upper half of the address space
`define CL_CHR_BASE 22'h200000

// Cycles the machine stays in reset once loading has finished
`define CL_RESET_HOLD 255

`endif
